//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = wiscCoreTb
FILELIST  = wiscCore.f
OBJDIR    = obj_dir
PASSTEXT  = No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "^$(PASSTEXT)$$"

clean:
	rm -rf $(OBJDIR)

//--- hdl/execUnit.sv
`timescale 1ns/100ps

module execUnit (
  input  logic            clk,
  input  logic            rstN,
  input  wiscPkg::decodeT deReg,
  output wiscPkg::execT   erReg
);
  import wiscPkg::*;

  wordT        aluA;
  wordT        aluB;
  wordT        aluOut;
  wordT        reversed;
  wordT        pcPlus2;
  wordT        jumpTarget;
  wordT        newPc;
  logic [3:0]  shAmt;
  logic [4:0]  shBack;
  logic [16:0] sumCarry;
  logic        taken;
  execT        exNext;

  assign aluA     = deReg.opA;
  assign aluB     = deReg.useImm ? deReg.imm : deReg.opB;
  assign shAmt    = aluB[3:0];
  assign shBack   = 5'd16 - {1'b0, shAmt};
  assign sumCarry = {1'b0, aluA} + {1'b0, aluB};

  always_comb begin
    for (int i = 0; i < 16; i++) begin
      reversed[i] = aluA[15 - i];
    end
  end

  // ----------------------------------------
  // ALU and shifter
  // ----------------------------------------
  always_comb begin
    case (deReg.aluOp)
      aluAdd:   aluOut = sumCarry[15:0];
      // subtract follows the ISA order, Rt or imm minus Rs.
      aluSub:   aluOut = aluB - aluA;
      aluXor:   aluOut = aluA ^ aluB;
      aluAndn:  aluOut = aluA & ~aluB;
      aluRol:   aluOut = (aluA << shAmt) | (aluA >> shBack);
      aluSll:   aluOut = aluA << shAmt;
      aluRor:   aluOut = (aluA >> shAmt) | (aluA << shBack);
      aluSrl:   aluOut = aluA >> shAmt;
      aluSeq:   aluOut = {15'b0, aluA == aluB};
      aluSlt:   aluOut = {15'b0, $signed(aluA) < $signed(aluB)};
      aluSle:   aluOut = {15'b0, $signed(aluA) <= $signed(aluB)};
      aluSco:   aluOut = {15'b0, sumCarry[16]};
      aluPassB: aluOut = aluB;
      aluSlbi:  aluOut = {aluA[7:0], 8'b0} | aluB;
      aluBtr:   aluOut = reversed;
      default:  aluOut = sumCarry[15:0];
    endcase
  end

  // ----------------------------------------
  // next pc
  // ----------------------------------------
  always_comb begin
    unique case (deReg.brCond)
      2'b00: taken = (aluA == '0);
      2'b01: taken = (aluA != '0);
      2'b10: taken = aluA[15];
      2'b11: taken = ~aluA[15];
    endcase
  end

  assign pcPlus2    = deReg.pc + 16'd2;
  assign jumpTarget = (deReg.jumpReg ? aluA : pcPlus2) + deReg.imm;

  // the SIIC vector itself is applied in the result stage.
  always_comb begin
    unique case (deReg.nextPc)
      pcSeq:    newPc = pcPlus2;
      pcBranch: newPc = taken ? jumpTarget : pcPlus2;
      pcJump:   newPc = jumpTarget;
      pcVector: newPc = pcPlus2;
    endcase
  end

  always_comb begin
    exNext           = '0;
    exNext.valid     = deReg.valid;
    exNext.result    = deReg.linkWrite ? pcPlus2 : aluOut;
    exNext.storeData = deReg.storeData;
    exNext.memRead   = deReg.memRead;
    exNext.memWrite  = deReg.memWrite;
    exNext.regWrite  = deReg.regWrite | deReg.stuWrite | deReg.linkWrite;
    exNext.rd        = deReg.rd;
    exNext.newPc     = newPc;
    exNext.toVector  = (deReg.nextPc == pcVector);
    exNext.halt      = deReg.halt;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      erReg <= '0;
    end else begin
      erReg <= exNext;
    end
  end

endmodule

//--- hdl/instrDecode.sv
`timescale 1ns/100ps

module instrDecode (
  input  logic             clk,
  input  logic             rstN,
  input  wiscPkg::wordT    instr,
  input  wiscPkg::wordT    pc,
  input  logic             retire,
  input  logic             halted,
  output wiscPkg::regIdxT  rsIdx,
  output wiscPkg::regIdxT  rtIdx,
  input  wiscPkg::wordT    rsData,
  input  wiscPkg::wordT    rtData,
  output wiscPkg::decodeT  deReg
);
  import wiscPkg::*;

  opcodeT opcode;
  logic   inFlight;
  logic   issue;
  logic   rForm;
  logic   rsDest;
  logic   linkDest;
  regIdxT rd;
  wordT   immS5;
  wordT   immZ5;
  wordT   immS8;
  wordT   immZ8;
  wordT   immS11;
  decodeT deNext;

  assign opcode = opcodeT'(instr[15:11]);

  // only one instruction is ever in flight, so issue waits for retire.
  assign issue = ~inFlight & ~halted;

  // ----------------------------------------
  // register fields
  // ----------------------------------------
  // BTR and the 11010..11111 group carry rd in bits 4:2.
  assign rForm    = (&instr[15:14]) & (|instr[13:11]);
  // LBI, SLBI and STU write back to the Rs field.
  assign rsDest   = ((&instr[15:14]) & ~(|instr[13:11])) |
                    (instr[15] & ~(|instr[14:13]) & instr[12]);
  // SIIC, JAL and JALR write the link register.
  assign linkDest = ~(|instr[15:14]) & instr[12] & (instr[13] | ~instr[11]);

  // RTI returns through R7, so it reads R7 in place of Rs.
  assign rsIdx = (opcode == opRti) ? linkReg : instr[10:8];
  assign rtIdx = instr[7:5];

  assign rd = linkDest ? linkReg     :
              rsDest   ? instr[10:8] :
              rForm    ? instr[4:2]  : instr[7:5];

  assign immS5  = {{11{instr[4]}}, instr[4:0]};
  assign immZ5  = {11'b0, instr[4:0]};
  assign immS8  = {{8{instr[7]}}, instr[7:0]};
  assign immZ8  = {8'b0, instr[7:0]};
  assign immS11 = {{5{instr[10]}}, instr[10:0]};

  // ----------------------------------------
  // control decode
  // ----------------------------------------
  always_comb begin
    deNext           = '0;
    deNext.valid     = 1'b1;
    deNext.pc        = pc;
    deNext.opA       = rsData;
    deNext.opB       = rtData;
    deNext.storeData = rtData;
    deNext.imm       = immS5;
    deNext.aluOp     = aluAdd;
    deNext.nextPc    = pcSeq;
    deNext.brCond    = instr[12:11];
    deNext.rd        = rd;
    unique case (opcode)
      opHalt: deNext.halt = 1'b1;
      opNop: ;
      opSiic: begin
        deNext.linkWrite = 1'b1;
        deNext.nextPc    = pcVector;
      end
      opRti: begin
        deNext.nextPc  = pcJump;
        deNext.jumpReg = 1'b1;
        deNext.imm     = '0;
      end
      opJ, opJal: begin
        deNext.nextPc    = pcJump;
        deNext.imm       = immS11;
        deNext.linkWrite = instr[12];
      end
      opJr, opJalr: begin
        deNext.nextPc    = pcJump;
        deNext.jumpReg   = 1'b1;
        deNext.imm       = immS8;
        deNext.linkWrite = instr[12];
      end
      opAddi, opSubi, opXori, opAndni: begin
        deNext.regWrite = 1'b1;
        deNext.useImm   = 1'b1;
        deNext.aluOp    = aluOpT'({2'b00, instr[12:11]});
        // XORI and ANDNI take a zero-extended immediate.
        if (instr[12]) begin
          deNext.imm = immZ5;
        end
      end
      opBeqz, opBnez, opBltz, opBgez: begin
        deNext.nextPc = pcBranch;
        deNext.imm    = immS8;
      end
      opSt: begin
        deNext.memWrite = 1'b1;
        deNext.useImm   = 1'b1;
      end
      opLd: begin
        deNext.memRead  = 1'b1;
        deNext.regWrite = 1'b1;
        deNext.useImm   = 1'b1;
      end
      opSlbi: begin
        deNext.regWrite = 1'b1;
        deNext.useImm   = 1'b1;
        deNext.aluOp    = aluSlbi;
        deNext.imm      = immZ8;
      end
      opStu: begin
        deNext.memWrite = 1'b1;
        deNext.stuWrite = 1'b1;
        deNext.useImm   = 1'b1;
      end
      opRoli, opSlli, opRori, opSrli: begin
        deNext.regWrite = 1'b1;
        deNext.useImm   = 1'b1;
        deNext.aluOp    = aluOpT'({2'b01, instr[12:11]});
      end
      opLbi: begin
        deNext.regWrite = 1'b1;
        deNext.useImm   = 1'b1;
        deNext.aluOp    = aluPassB;
        deNext.imm      = immS8;
      end
      opBtr: begin
        deNext.regWrite = 1'b1;
        deNext.aluOp    = aluBtr;
      end
      opAluR, opShiftR: begin
        deNext.regWrite = 1'b1;
        deNext.aluOp    = aluOpT'({1'b0, instr[11], instr[1:0]});
      end
      opSeq, opSlt, opSle, opSco: begin
        deNext.regWrite = 1'b1;
        deNext.aluOp    = aluOpT'({2'b10, instr[12:11]});
      end
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      inFlight <= 1'b0;
      deReg    <= '0;
    end else begin
      if (issue) begin
        inFlight <= 1'b1;
      end else if (retire) begin
        inFlight <= 1'b0;
      end
      if (issue) begin
        deReg <= deNext;
      end else begin
        deReg.valid <= 1'b0;
      end
    end
  end

endmodule

//--- hdl/regFile.sv
`timescale 1ns/100ps

module regFile (
  input  logic            clk,
  input  logic            rstN,
  input  wiscPkg::regIdxT rsIdx,
  input  wiscPkg::regIdxT rtIdx,
  output wiscPkg::wordT   rsData,
  output wiscPkg::wordT   rtData,
  input  logic            wrEn,
  input  wiscPkg::regIdxT wrIdx,
  input  wiscPkg::wordT   wrData
);
  import wiscPkg::*;

  wordT regs [8];

  // writes land at the end of the retire cycle, and the next read
  // happens at a later issue, so no bypass is needed.
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < 8; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn) begin
      regs[wrIdx] <= wrData;
    end
  end

  assign rsData = regs[rsIdx];
  assign rtData = regs[rtIdx];

endmodule

//--- hdl/resultStage.sv
`timescale 1ns/100ps

module resultStage #(
  parameter wiscPkg::wordT resetPc    = 16'h0000,
  parameter wiscPkg::wordT siicVector = 16'h0002
) (
  input  logic            clk,
  input  logic            rstN,
  input  wiscPkg::execT   erReg,
  output wiscPkg::wordT   memAddr,
  output wiscPkg::wordT   memWdata,
  output logic            memRe,
  output logic            memWe,
  input  wiscPkg::wordT   memRdata,
  output logic            wrEn,
  output wiscPkg::regIdxT wrIdx,
  output wiscPkg::wordT   wrData,
  output wiscPkg::wordT   pc,
  output logic            retire,
  output logic            halted
);
  import wiscPkg::*;

  wordT pcNext;

  // ----------------------------------------
  // memory and writeback
  // ----------------------------------------
  assign memAddr  = erReg.result;
  assign memWdata = erReg.storeData;
  assign memRe    = erReg.valid & erReg.memRead;
  assign memWe    = erReg.valid & erReg.memWrite;

  // STU writes its computed address back, which is already the result.
  assign wrEn   = erReg.valid & erReg.regWrite;
  assign wrIdx  = erReg.rd;
  assign wrData = erReg.memRead ? memRdata : erReg.result;

  assign retire = erReg.valid;

  // ----------------------------------------
  // pc and halt
  // ----------------------------------------
  assign pcNext = erReg.toVector ? siicVector : erReg.newPc;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc     <= resetPc;
      halted <= 1'b0;
    end else if (erReg.valid) begin
      pc <= pcNext;
      if (erReg.halt) begin
        halted <= 1'b1;
      end
    end
  end

endmodule

//--- hdl/wiscCore.sv
`timescale 1ns/100ps

module wiscCore #(
  parameter wiscPkg::wordT resetPc    = 16'h0000,
  parameter wiscPkg::wordT siicVector = 16'h0002
) (
  input  logic          clk,
  input  logic          rstN,
  output wiscPkg::wordT pc,
  input  wiscPkg::wordT instr,
  output wiscPkg::wordT memAddr,
  output wiscPkg::wordT memWdata,
  output logic          memRe,
  output logic          memWe,
  input  wiscPkg::wordT memRdata,
  output logic          retire,
  output logic          halted
);
  import wiscPkg::*;

  regIdxT rsIdx;
  regIdxT rtIdx;
  wordT   rsData;
  wordT   rtData;
  decodeT deReg;
  execT   erReg;
  logic   wrEn;
  regIdxT wrIdx;
  wordT   wrData;

  instrDecode instrDecode_inst (
    .clk    (clk),
    .rstN   (rstN),
    .instr  (instr),
    .pc     (pc),
    .retire (retire),
    .halted (halted),
    .rsIdx  (rsIdx),
    .rtIdx  (rtIdx),
    .rsData (rsData),
    .rtData (rtData),
    .deReg  (deReg)
  );

  regFile regFile_inst (
    .clk    (clk),
    .rstN   (rstN),
    .rsIdx  (rsIdx),
    .rtIdx  (rtIdx),
    .rsData (rsData),
    .rtData (rtData),
    .wrEn   (wrEn),
    .wrIdx  (wrIdx),
    .wrData (wrData)
  );

  execUnit execUnit_inst (
    .clk   (clk),
    .rstN  (rstN),
    .deReg (deReg),
    .erReg (erReg)
  );

  resultStage #(
    .resetPc    (resetPc),
    .siicVector (siicVector)
  ) resultStage_inst (
    .clk      (clk),
    .rstN     (rstN),
    .erReg    (erReg),
    .memAddr  (memAddr),
    .memWdata (memWdata),
    .memRe    (memRe),
    .memWe    (memWe),
    .memRdata (memRdata),
    .wrEn     (wrEn),
    .wrIdx    (wrIdx),
    .wrData   (wrData),
    .pc       (pc),
    .retire   (retire),
    .halted   (halted)
  );

endmodule

//--- hdl/wiscPkg.sv
package wiscPkg;

  typedef logic [15:0] wordT;
  typedef logic [2:0]  regIdxT;

  // the link register receives PC+2 on JAL, JALR and SIIC.
  localparam regIdxT linkReg = 3'd7;

  // ----------------------------------------
  // opcode map, instr[15:11]
  // ----------------------------------------
  typedef enum logic [4:0] {
    opHalt   = 5'b00000,
    opNop    = 5'b00001,
    opSiic   = 5'b00010,
    opRti    = 5'b00011,
    opJ      = 5'b00100,
    opJr     = 5'b00101,
    opJal    = 5'b00110,
    opJalr   = 5'b00111,
    opAddi   = 5'b01000,
    opSubi   = 5'b01001,
    opXori   = 5'b01010,
    opAndni  = 5'b01011,
    opBeqz   = 5'b01100,
    opBnez   = 5'b01101,
    opBltz   = 5'b01110,
    opBgez   = 5'b01111,
    opSt     = 5'b10000,
    opLd     = 5'b10001,
    opSlbi   = 5'b10010,
    opStu    = 5'b10011,
    opRoli   = 5'b10100,
    opSlli   = 5'b10101,
    opRori   = 5'b10110,
    opSrli   = 5'b10111,
    opLbi    = 5'b11000,
    opBtr    = 5'b11001,
    opAluR   = 5'b11010,
    opShiftR = 5'b11011,
    opSeq    = 5'b11100,
    opSlt    = 5'b11101,
    opSle    = 5'b11110,
    opSco    = 5'b11111
  } opcodeT;

  // the low two bits of each group line up with instr[12:11] or FUNC.
  typedef enum logic [3:0] {
    aluAdd   = 4'h0,
    aluSub   = 4'h1,
    aluXor   = 4'h2,
    aluAndn  = 4'h3,
    aluRol   = 4'h4,
    aluSll   = 4'h5,
    aluRor   = 4'h6,
    aluSrl   = 4'h7,
    aluSeq   = 4'h8,
    aluSlt   = 4'h9,
    aluSle   = 4'ha,
    aluSco   = 4'hb,
    aluPassB = 4'hc,
    aluSlbi  = 4'hd,
    aluBtr   = 4'he
  } aluOpT;

  typedef enum logic [1:0] {
    pcSeq    = 2'd0,
    pcBranch = 2'd1,
    pcJump   = 2'd2,
    pcVector = 2'd3
  } nextPcT;

  // ----------------------------------------
  // stage payloads
  // ----------------------------------------
  typedef struct packed {
    logic       valid;
    wordT       pc;
    wordT       opA;
    wordT       opB;
    wordT       imm;
    logic       useImm;
    aluOpT      aluOp;
    nextPcT     nextPc;
    logic [1:0] brCond;
    logic       jumpReg;
    logic       memRead;
    logic       memWrite;
    logic       regWrite;
    logic       linkWrite;
    regIdxT     rd;
    logic       halt;
    logic       stuWrite;
    wordT       storeData;
  } decodeT;

  typedef struct packed {
    logic   valid;
    wordT   result;
    wordT   storeData;
    logic   memRead;
    logic   memWrite;
    logic   regWrite;
    regIdxT rd;
    wordT   newPc;
    logic   toVector;
    logic   halt;
  } execT;

endpackage

//--- test/wiscCoreTb.sv
`timescale 1ns/100ps

module wiscCoreTb;
  import wiscPkg::*;

  localparam wordT resetPc     = 16'h0000;
  localparam wordT siicVector  = 16'h0002;
  localparam int   haltTimeout = 2000;

  logic  clk;
  logic  rstN;
  wordT  pc;
  wordT  instr;
  wordT  memAddr;
  wordT  memWdata;
  wordT  memRdata;
  logic  memRe;
  logic  memWe;
  logic  retire;
  logic  halted;

  wordT  imem [256];
  wordT  dmem [256];

  int    progLen;
  int    nextAddr;
  int    seed;
  int    checks;
  int    mismatches;
  int    failures;
  wordT  expAddr [$];
  wordT  expData [$];
  string expLabel [$];
  wordT  expLoad [$];

  wiscCore #(
    .resetPc    (resetPc),
    .siicVector (siicVector)
  ) wiscCore_inst (
    .clk      (clk),
    .rstN     (rstN),
    .pc       (pc),
    .instr    (instr),
    .memAddr  (memAddr),
    .memWdata (memWdata),
    .memRe    (memRe),
    .memWe    (memWe),
    .memRdata (memRdata),
    .retire   (retire),
    .halted   (halted)
  );

  initial begin
    clk = 1'b0;
  end

  always #2 clk = ~clk;

  // ----------------------------------------
  // memory models
  // ----------------------------------------
  // both memories are word arrays indexed by the byte address.
  assign instr    = imem[pc[8:1]];
  assign memRdata = dmem[memAddr[8:1]];

  always @(posedge clk) begin
    if (memWe) begin
      dmem[memAddr[8:1]] <= memWdata;
    end
  end

  // ----------------------------------------
  // program building
  // ----------------------------------------
  function automatic wordT encI(logic [4:0] op, regIdxT rs, regIdxT rt, logic [4:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic wordT encR(logic [4:0] op, regIdxT rs, regIdxT rt, regIdxT rd,
                                logic [1:0] func);
    return {op, rs, rt, rd, func};
  endfunction

  function automatic wordT encL(logic [4:0] op, regIdxT rs, logic [7:0] imm);
    return {op, rs, imm};
  endfunction

  function automatic wordT encJ(logic [4:0] op, logic [10:0] disp);
    return {op, disp};
  endfunction

  task automatic emit(wordT w);
    imem[progLen] = w;
    progLen++;
  endtask

  task automatic loadConst(regIdxT r, wordT value);
    emit(encL(opLbi, r, value[15:8]));
    emit(encL(opSlbi, r, value[7:0]));
  endtask

  // R6 is kept free as the store base register.
  task automatic storeReg(regIdxT rt, wordT value, string label);
    emit(encL(opLbi, 3'd6, 8'(nextAddr)));
    emit(encI(opSt, 3'd6, rt, 5'd0));
    expAddr.push_back(16'(nextAddr));
    expData.push_back(value);
    expLabel.push_back(label);
    nextAddr += 2;
  endtask

  // ----------------------------------------
  // reference model from the ISA rules
  // ----------------------------------------
  function automatic wordT aluRef(int f, wordT a, wordT b);
    case (f)
      0: return a + b;
      1: return b - a;
      2: return a ^ b;
      default: return a & ~b;
    endcase
  endfunction

  function automatic wordT shiftRef(int f, wordT a, logic [3:0] n);
    wordT r;
    r = a;
    for (int i = 0; i < int'(n); i++) begin
      case (f)
        0: r = {r[14:0], r[15]};
        1: r = {r[14:0], 1'b0};
        2: r = {r[0], r[15:1]};
        default: r = {1'b0, r[15:1]};
      endcase
    end
    return r;
  endfunction

  function automatic wordT cmpRef(int f, wordT a, wordT b);
    logic [16:0] wide;
    wide = {1'b0, a} + {1'b0, b};
    case (f)
      0: return {15'b0, a == b};
      1: return {15'b0, $signed(a) < $signed(b)};
      2: return {15'b0, $signed(a) <= $signed(b)};
      default: return {15'b0, wide[16]};
    endcase
  endfunction

  function automatic wordT reverseBits(wordT a);
    wordT r;
    for (int i = 0; i < 16; i++) begin
      r[15 - i] = a[i];
    end
    return r;
  endfunction

  // ----------------------------------------
  // run control and checking
  // ----------------------------------------
  task automatic beginProgram();
    progLen  = 0;
    nextAddr = 16'h20;
    expAddr.delete();
    expData.delete();
    expLabel.delete();
    expLoad.delete();
    // unused program words are HALT with the address in the low bits.
    for (int i = 0; i < 256; i++) begin
      imem[i] = {5'b00000, 11'(i)};
      dmem[i] <= {8'(i), ~8'(i)};
    end
    @(posedge clk);
    rstN <= 1'b0;
  endtask

  task automatic checkStore();
    if (expAddr.size() == 0) begin
      failures++;
      $display("unexpected store to %h at %0t", memAddr, $time);
    end else begin
      checks += 2;
      assert (memAddr == expAddr[0]) else begin
        mismatches++;
        $display("mismatch at %0t: memAddr (%s) expected %h, got %h",
                 $time, expLabel[0], expAddr[0], memAddr);
      end
      assert (memWdata == expData[0]) else begin
        mismatches++;
        $display("mismatch at %0t: memWdata (%s) expected %h, got %h",
                 $time, expLabel[0], expData[0], memWdata);
      end
      void'(expAddr.pop_front());
      void'(expData.pop_front());
      void'(expLabel.pop_front());
    end
  endtask

  task automatic checkLoad();
    if (expLoad.size() == 0) begin
      failures++;
      $display("unexpected load from %h at %0t", memAddr, $time);
    end else begin
      checks++;
      assert (memAddr == expLoad[0]) else begin
        mismatches++;
        $display("mismatch at %0t: memAddr (load) expected %h, got %h",
                 $time, expLoad[0], memAddr);
      end
      void'(expLoad.pop_front());
    end
  endtask

  task automatic runProgram(string name);
    int cycles;
    int lastRetire;
    cycles     = 0;
    lastRetire = -1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    checks += 2;
    assert (pc == resetPc) else begin
      mismatches++;
      $display("mismatch at %0t: pc expected %h, got %h", $time, resetPc, pc);
    end
    assert (!retire && !halted && !memRe && !memWe) else begin
      failures++;
      $display("outputs not cleared by reset in test %s", name);
    end
    @(posedge clk);
    rstN <= 1'b1;
    while (!halted && cycles < haltTimeout) begin
      @(negedge clk);
      cycles++;
      if (memWe) begin
        checkStore();
      end
      if (memRe) begin
        checkLoad();
      end
      if (retire) begin
        checks++;
        if (lastRetire >= 0) begin
          assert (cycles - lastRetire == 3) else begin
            failures++;
            $display("retire came %0d cycles after the previous one in test %s",
                     cycles - lastRetire, name);
          end
        end else begin
          // the first instruction retires in the third cycle after reset.
          assert (cycles == 3) else begin
            failures++;
            $display("first retire came in cycle %0d in test %s", cycles, name);
          end
        end
        lastRetire = cycles;
      end
    end
    if (!halted) begin
      failures++;
      $display("timeout waiting for halted in test %s", name);
    end
    checks++;
    assert (expAddr.size() == 0) else begin
      failures++;
      $display("test %s ended with %0d stores missing", name, expAddr.size());
    end
    checks++;
    assert (expLoad.size() == 0) else begin
      failures++;
      $display("test %s ended with %0d loads missing", name, expLoad.size());
    end
    // once halted the core must stay quiet.
    repeat (6) begin
      @(negedge clk);
      checks++;
      assert (halted && !retire && !memWe && !memRe) else begin
        failures++;
        $display("core active after halt in test %s at %0t", name, $time);
      end
    end
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  task automatic immTest();
    logic [7:0] b1;
    logic [7:0] b2;
    logic [4:0] i1;
    logic [4:0] i2;
    logic [4:0] i3;
    logic [4:0] i4;
    wordT       r1;
    beginProgram();
    b1 = 8'($random(seed));
    b2 = 8'($random(seed));
    i1 = 5'($random(seed));
    i2 = 5'($random(seed)) | 5'h10;
    i3 = 5'($random(seed)) | 5'h10;
    i4 = 5'($random(seed)) | 5'h10;
    emit(encL(opLbi, 3'd1, b1));
    r1 = {{8{b1[7]}}, b1};
    storeReg(3'd1, r1, "LBI");
    emit(encL(opSlbi, 3'd1, b2));
    r1 = {r1[7:0], b2};
    storeReg(3'd1, r1, "SLBI");
    emit(encI(opAddi, 3'd1, 3'd2, i1));
    storeReg(3'd2, r1 + {{11{i1[4]}}, i1}, "ADDI");
    emit(encI(opSubi, 3'd1, 3'd3, i2));
    storeReg(3'd3, {{11{i2[4]}}, i2} - r1, "SUBI");
    emit(encI(opXori, 3'd1, 3'd4, i3));
    storeReg(3'd4, r1 ^ {11'b0, i3}, "XORI");
    emit(encI(opAndni, 3'd1, 3'd5, i4));
    storeReg(3'd5, r1 & ~{11'b0, i4}, "ANDNI");
    emit(16'h0000);
    runProgram("immediate");
  endtask

  task automatic aluTest();
    wordT       a;
    wordT       b;
    logic [4:0] imm;
    beginProgram();
    a = 16'($random(seed));
    b = 16'($random(seed));
    loadConst(3'd1, a);
    loadConst(3'd2, b);
    for (int f = 0; f < 4; f++) begin
      emit(encR(opAluR, 3'd1, 3'd2, 3'd3, 2'(f)));
      storeReg(3'd3, aluRef(f, a, b), $sformatf("alu func %0d", f));
      emit(encR(opShiftR, 3'd1, 3'd2, 3'd3, 2'(f)));
      storeReg(3'd3, shiftRef(f, a, b[3:0]), $sformatf("shift func %0d", f));
      imm = 5'($random(seed));
      emit(encI({3'b101, 2'(f)}, 3'd1, 3'd4, imm));
      storeReg(3'd4, shiftRef(f, a, imm[3:0]), $sformatf("shift imm %0d", f));
    end
    emit(encR(opBtr, 3'd1, 3'd0, 3'd5, 2'b00));
    storeReg(3'd5, reverseBits(a), "BTR");
    emit(16'h0000);
    runProgram("alu");
  endtask

  task automatic cmpTest();
    wordT pa [5];
    wordT pb [5];
    beginProgram();
    pa[0] = 16'($random(seed));
    pb[0] = 16'($random(seed));
    pa[1] = 16'($random(seed));
    pb[1] = pa[1];
    pa[2] = 16'h7fff;
    pb[2] = 16'h8000;
    pa[3] = 16'hffff;
    pb[3] = 16'h0001;
    pa[4] = 16'h8000;
    pb[4] = 16'h7fff;
    for (int p = 0; p < 5; p++) begin
      loadConst(3'd1, pa[p]);
      loadConst(3'd2, pb[p]);
      for (int f = 0; f < 4; f++) begin
        emit(encR({3'b111, 2'(f)}, 3'd1, 3'd2, 3'd3, 2'b00));
        storeReg(3'd3, cmpRef(f, pa[p], pb[p]), $sformatf("compare %0d pair %0d", f, p));
      end
    end
    emit(16'h0000);
    runProgram("compare");
  endtask

  task automatic branchTest();
    wordT vals [3];
    logic taken;
    wordT target;
    wordT link;
    beginProgram();
    vals[0] = 16'h0000;
    vals[1] = 16'h1234;
    vals[2] = 16'h8001;
    // a taken branch or jump skips the LBI that overwrites the marker.
    for (int f = 0; f < 4; f++) begin
      for (int v = 0; v < 3; v++) begin
        case (f)
          0: taken = (vals[v] == 16'h0);
          1: taken = (vals[v] != 16'h0);
          2: taken = vals[v][15];
          default: taken = ~vals[v][15];
        endcase
        loadConst(3'd1, vals[v]);
        emit(encL(opLbi, 3'd5, 8'h11));
        emit(encL({3'b011, 2'(f)}, 3'd1, 8'd2));
        emit(encL(opLbi, 3'd5, 8'h55));
        storeReg(3'd5, taken ? 16'h0011 : 16'h0055, $sformatf("branch %0d value %0d", f, v));
      end
    end
    emit(encL(opLbi, 3'd5, 8'h11));
    emit(encJ(opJ, 11'd2));
    emit(encL(opLbi, 3'd5, 8'h55));
    storeReg(3'd5, 16'h0011, "J");
    emit(encL(opLbi, 3'd5, 8'h11));
    link = 16'(2 * progLen + 2);
    emit(encJ(opJal, 11'd2));
    emit(encL(opLbi, 3'd5, 8'h55));
    storeReg(3'd5, 16'h0011, "JAL");
    storeReg(3'd7, link, "JAL link");
    for (int k = 0; k < 2; k++) begin
      emit(encL(opLbi, 3'd5, 8'h11));
      target = 16'(2 * (progLen + 4));
      link   = 16'(2 * (progLen + 2) + 2);
      loadConst(3'd2, target - 16'd4);
      emit(encL(k == 0 ? opJr : opJalr, 3'd2, 8'd4));
      emit(encL(opLbi, 3'd5, 8'h55));
      storeReg(3'd5, 16'h0011, k == 0 ? "JR" : "JALR");
    end
    storeReg(3'd7, link, "JALR link");
    emit(16'h0000);
    runProgram("branch");
  endtask

  task automatic memTest();
    wordT ldVal;
    wordT stuVal;
    beginProgram();
    ldVal  = 16'($random(seed));
    stuVal = 16'($random(seed));
    dmem[8'h31] <= ldVal;
    emit(encL(opLbi, 3'd6, 8'h60));
    emit(encI(opLd, 3'd6, 3'd1, 5'd2));
    expLoad.push_back(16'h0062);
    storeReg(3'd1, ldVal, "LD");
    loadConst(3'd3, 16'h00a0);
    loadConst(3'd4, stuVal);
    // STU with offset -2 stores at 0x9e and leaves 0x9e in R3.
    emit(encI(opStu, 3'd3, 3'd4, 5'h1e));
    expAddr.push_back(16'h009e);
    expData.push_back(stuVal);
    expLabel.push_back("STU");
    storeReg(3'd3, 16'h009e, "STU base");
    emit(encI(opLd, 3'd3, 3'd2, 5'd0));
    expLoad.push_back(16'h009e);
    storeReg(3'd2, stuVal, "LD after STU");
    // the NOP register fields name R4 and R1, which are checked below.
    emit(encI(opNop, 3'd4, 3'd4, 5'h1f));
    emit(encI(opNop, 3'd1, 3'd1, 5'd0));
    storeReg(3'd4, stuVal, "NOP R4");
    storeReg(3'd1, ldVal, "NOP R1");
    emit(16'h0000);
    runProgram("memory");
  endtask

  task automatic siicTest();
    wordT siicPc;
    beginProgram();
    emit(16'h0000);
    // the handler sits at the vector and returns through R7.
    emit(encL(opLbi, 3'd5, 8'h5a));
    storeReg(3'd5, 16'h005a, "SIIC handler");
    emit({opRti, 11'd0});
    imem[0] = encJ(opJ, 11'(2 * progLen - 2));
    siicPc = 16'(2 * progLen);
    emit({opSiic, 11'd0});
    storeReg(3'd7, siicPc + 16'd2, "SIIC link");
    emit(16'h0000);
    runProgram("siic");
  endtask

  initial begin
    rstN       = 1'b0;
    seed       = 6899;
    checks     = 0;
    mismatches = 0;
    failures   = 0;
    immTest();
    aluTest();
    cmpTest();
    branchTest();
    memTest();
    siicTest();
    $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- test/wiscCore_assert.sv
`timescale 1ns/100ps

module wiscCoreAssert (
  input logic clk,
  input logic rstN,
  input logic memRe,
  input logic memWe,
  input logic retire,
  input logic halted
);

  noBothStrobes: assert property (@(posedge clk) disable iff (!rstN) !(memRe && memWe))
    else $error("memRe and memWe high in the same cycle");

  // one instruction in flight means retires never touch.
  retireGap: assert property (@(posedge clk) disable iff (!rstN) retire |=> !retire)
    else $error("retire high in two consecutive cycles");

  haltSticky: assert property (@(posedge clk) disable iff (!rstN) halted |=> halted)
    else $error("halted fell without reset");

  quietAfterHalt: assert property (@(posedge clk) disable iff (!rstN) halted |-> !(memRe || memWe))
    else $error("memory strobe after halted");

endmodule

bind wiscCore wiscCoreAssert wiscCoreAssert_inst (
  .clk    (clk),
  .rstN   (rstN),
  .memRe  (memRe),
  .memWe  (memWe),
  .retire (retire),
  .halted (halted)
);

//--- wiscCore.f
hdl/wiscPkg.sv
hdl/instrDecode.sv
hdl/regFile.sv
hdl/execUnit.sv
hdl/resultStage.sv
hdl/wiscCore.sv
test/wiscCore_assert.sv
test/wiscCoreTb.sv
